//--- src/l15_share_config.svh
`ifndef L15_SHARE_CONFIG_SVH
`define L15_SHARE_CONFIG_SVH

// Bus widths
`define L15_ADDR_W 32
`define L15_DATA_W 64
`define L15_WORD_W 32

// L1.5 request type codes
`define L15_RQ_LOAD  5'b00000
`define L15_RQ_STORE 5'b00001
`define L15_RQ_IMISS 5'b10000

// Width of the request type and size fields
`define L15_RQTYPE_W 5
`define L15_RQSIZE_W 3

`define L15_SIZE_WORD 3'b010 // 4-byte access

`endif

//--- src/l15_share_pkg.sv
`include "l15_share_config.svh"

package l15_share_pkg;

	// Byte address toward the L1.5
	typedef logic [`L15_ADDR_W-1:0] addr_t;

	// Client-side instruction or data word
	typedef logic [`L15_WORD_W-1:0] word_t;

	// One 64-bit L1.5 data beat
	typedef logic [`L15_DATA_W-1:0] dword_t;

	typedef logic [`L15_RQTYPE_W-1:0] rqtype_t; // Request type field
	typedef logic [`L15_RQSIZE_W-1:0] rqsize_t; // Size code field

	// Port ownership states
	typedef enum logic [1:0] {
		arb_instr, // Fetch client owns the port
		arb_wait,  // Draining a fetch response
		arb_mem    // Data client owns the port
	} arb_state_t;

endpackage

//--- src/fetch_client.sv
`timescale 1ns/1ps

module fetch_client (
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  fetch_req,
	input  l15_share_pkg::addr_t  fetch_addr,
	input  logic                  header_ack,
	input  logic                  resp_val,
	input  l15_share_pkg::dword_t resp_data,
	output logic                  fetch_valid,
	output l15_share_pkg::word_t  fetch_instr,
	output logic                  fetch_wait_resp,
	output logic                  rq_val,
	output l15_share_pkg::addr_t  rq_address,
	output logic                  req_ack
);
	import l15_share_pkg::*;

	typedef enum logic [1:0] {
		f_idle,
		f_req,  // Request held on the port
		f_resp  // Granted, awaiting the fill
	} fetch_state_t;

	fetch_state_t state;
	addr_t        addr_q;
	word_t        sel_word;

	// Pick the 32-bit half addressed by bit 2
	assign sel_word = addr_q[2] ? resp_data[63:32] : resp_data[31:0];

	assign rq_val          = (state == f_req);
	assign rq_address      = addr_q;
	assign fetch_wait_resp = (state == f_resp);
	assign req_ack         = (state == f_resp) && resp_val; // Same-cycle response ack

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state       <= f_idle;
			fetch_valid <= 1'b0;
		end
		else
		begin
			fetch_valid <= 1'b0;
			case (state)
				f_idle:
					if (fetch_req)
						state <= f_req;
				f_req:
					if (header_ack)
						state <= f_resp; // Grant seen
				f_resp:
					if (resp_val)
					begin
						state       <= f_idle;
						fetch_valid <= 1'b1;
					end
				default:
					state <= f_idle;
			endcase
		end
	end

	// Address and result payload
	always_ff @(posedge clk)
	begin
		if ((state == f_idle) && fetch_req)
			addr_q <= fetch_addr;
		if ((state == f_resp) && resp_val)
			fetch_instr <= sel_word;
	end

endmodule

//--- src/mem_client.sv
`timescale 1ns/1ps
`include "l15_share_config.svh"

module mem_client (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   mem_req,
	input  logic                   mem_wr,
	input  l15_share_pkg::rqsize_t mem_size,
	input  l15_share_pkg::addr_t   mem_addr,
	input  l15_share_pkg::word_t   mem_wdata,
	input  logic                   header_ack,
	input  logic                   ack,
	input  logic                   resp_val,
	input  l15_share_pkg::dword_t  resp_data,
	output logic                   mem_done,
	output l15_share_pkg::word_t   mem_rdata,
	output logic                   mem_pending,
	output logic                   mem_complete,
	output logic                   rq_val,
	output l15_share_pkg::rqtype_t rq_type,
	output l15_share_pkg::rqsize_t rq_size,
	output l15_share_pkg::addr_t   rq_address,
	output l15_share_pkg::dword_t  rq_data,
	output logic                   req_ack
);
	import l15_share_pkg::*;

	typedef enum logic [1:0] {
		m_idle,
		m_req,
		m_resp
	} mem_state_t;

	mem_state_t state;

	// Latched operation
	logic    wr_q;
	rqsize_t size_q;
	addr_t   addr_q;
	word_t   wdata_q;
	word_t   sel_word;

	assign sel_word = addr_q[2] ? resp_data[63:32] : resp_data[31:0];

	assign rq_val      = (state == m_req);
	assign mem_pending = (state == m_req); // Held, not yet granted
	assign rq_type     = wr_q ? `L15_RQ_STORE : `L15_RQ_LOAD;
	assign rq_size     = size_q;
	assign rq_address  = addr_q;
	assign rq_data     = {wdata_q, wdata_q}; // Store word in both halves

	// Stores finish on the L1.5 ack, loads on the response
	assign mem_complete = (state == m_resp) && (wr_q ? ack : resp_val);
	assign req_ack      = (state == m_resp) && resp_val;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state    <= m_idle;
			mem_done <= 1'b0;
		end
		else
		begin
			mem_done <= mem_complete;
			case (state)
				m_idle:
					if (mem_req)
						state <= m_req;
				m_req:
					if (header_ack)
						state <= m_resp;
				m_resp:
					if (mem_complete)
						state <= m_idle;
				default:
					state <= m_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == m_idle) && mem_req)
		begin
			wr_q    <= mem_wr;
			size_q  <= mem_size;
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
		end
		if (mem_complete && !wr_q)
			mem_rdata <= sel_word; // Load result
	end

endmodule

//--- src/port_arbiter.sv
`timescale 1ns/1ps
`include "l15_share_config.svh"

module port_arbiter (
	input  logic                   clk,
	input  logic                   nrst,
	input  logic                   mem_pending,
	input  logic                   mem_complete,
	input  logic                   fetch_wait_resp,
	input  logic                   f_val,
	input  l15_share_pkg::addr_t   f_address,
	input  logic                   f_req_ack,
	input  logic                   m_val,
	input  l15_share_pkg::rqtype_t m_type,
	input  l15_share_pkg::rqsize_t m_size,
	input  l15_share_pkg::addr_t   m_address,
	input  l15_share_pkg::dword_t  m_data,
	input  logic                   m_req_ack,
	input  logic                   l15_transducer_header_ack,
	input  logic                   l15_transducer_ack,
	input  logic                   l15_transducer_val,
	input  l15_share_pkg::dword_t  l15_transducer_data_0,
	output l15_share_pkg::rqtype_t transducer_l15_rqtype,
	output l15_share_pkg::rqsize_t transducer_l15_size,
	output l15_share_pkg::addr_t   transducer_l15_address,
	output l15_share_pkg::dword_t  transducer_l15_data,
	output logic                   transducer_l15_val,
	output logic                   transducer_l15_req_ack,
	output logic                   f_header_ack,
	output logic                   f_resp_val,
	output logic                   m_header_ack,
	output logic                   m_ack,
	output logic                   m_resp_val,
	output l15_share_pkg::dword_t  resp_data
);
	import l15_share_pkg::*;

	arb_state_t state;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			state <= arb_instr;
		else
		begin
			case (state)
				arb_instr:
					if (mem_pending)
						state <= arb_wait;
				arb_wait:
					if (!fetch_wait_resp)
						state <= arb_mem; // Fetch has drained
				arb_mem:
					if (mem_complete)
						state <= arb_instr;
				default:
					state <= arb_instr;
			endcase
		end
	end

	// Beat data goes to both clients, valids pick the owner
	assign resp_data = l15_transducer_data_0;

	always_comb
	begin
		// Fetch request fields by default
		transducer_l15_rqtype  = `L15_RQ_IMISS;
		transducer_l15_size    = `L15_SIZE_WORD;
		transducer_l15_address = f_address;
		transducer_l15_data    = '0;
		transducer_l15_val     = 1'b0;
		transducer_l15_req_ack = f_req_ack;
		f_header_ack           = 1'b0;
		f_resp_val             = 1'b0;
		m_header_ack           = 1'b0;
		m_ack                  = 1'b0;
		m_resp_val             = 1'b0;
		case (state)
			arb_instr:
			begin
				transducer_l15_val = f_val;
				f_header_ack       = l15_transducer_header_ack;
				f_resp_val         = l15_transducer_val;
			end
			arb_wait:
				f_resp_val = l15_transducer_val; // Request blanked, fill still returns
			arb_mem:
			begin
				transducer_l15_rqtype  = m_type;
				transducer_l15_size    = m_size;
				transducer_l15_address = m_address;
				transducer_l15_data    = m_data;
				transducer_l15_val     = m_val;
				transducer_l15_req_ack = m_req_ack;
				m_header_ack           = l15_transducer_header_ack;
				m_ack                  = l15_transducer_ack;
				m_resp_val             = l15_transducer_val;
			end
			default:
				transducer_l15_val = 1'b0;
		endcase
	end

endmodule

//--- src/l15_port_share.sv
`timescale 1ns/1ps

module l15_port_share (
	input  logic                   clk,
	input  logic                   nrst,
	// Fetch client
	input  logic                   fetch_req,
	input  l15_share_pkg::addr_t   fetch_addr,
	output logic                   fetch_valid,
	output l15_share_pkg::word_t   fetch_instr,
	// Data client
	input  logic                   mem_req,
	input  logic                   mem_wr,
	input  l15_share_pkg::rqsize_t mem_size,
	input  l15_share_pkg::addr_t   mem_addr,
	input  l15_share_pkg::word_t   mem_wdata,
	output logic                   mem_done,
	output l15_share_pkg::word_t   mem_rdata,
	// L1.5 request
	output l15_share_pkg::rqtype_t transducer_l15_rqtype,
	output l15_share_pkg::rqsize_t transducer_l15_size,
	output l15_share_pkg::addr_t   transducer_l15_address,
	output l15_share_pkg::dword_t  transducer_l15_data,
	output logic                   transducer_l15_val,
	input  logic                   l15_transducer_header_ack,
	input  logic                   l15_transducer_ack,
	// L1.5 response
	input  logic                   l15_transducer_val,
	input  l15_share_pkg::dword_t  l15_transducer_data_0,
	output logic                   transducer_l15_req_ack
);
	import l15_share_pkg::*;

	logic    f_val, f_req_ack, f_header_ack, f_resp_val, fetch_wait_resp;
	addr_t   f_address;
	logic    m_val, m_req_ack, m_header_ack, m_ack, m_resp_val;
	logic    mem_pending, mem_complete;
	rqtype_t m_type;
	rqsize_t m_size;
	addr_t   m_address;
	dword_t  m_data;
	dword_t  resp_data; // Shared response beat

	fetch_client u_fetch (
		.clk             (clk),
		.nrst            (nrst),
		.fetch_req       (fetch_req),
		.fetch_addr      (fetch_addr),
		.header_ack      (f_header_ack),
		.resp_val        (f_resp_val),
		.resp_data       (resp_data),
		.fetch_valid     (fetch_valid),
		.fetch_instr     (fetch_instr),
		.fetch_wait_resp (fetch_wait_resp),
		.rq_val          (f_val),
		.rq_address      (f_address),
		.req_ack         (f_req_ack)
	);

	mem_client u_mem (
		.clk          (clk),
		.nrst         (nrst),
		.mem_req      (mem_req),
		.mem_wr       (mem_wr),
		.mem_size     (mem_size),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.header_ack   (m_header_ack),
		.ack          (m_ack),
		.resp_val     (m_resp_val),
		.resp_data    (resp_data),
		.mem_done     (mem_done),
		.mem_rdata    (mem_rdata),
		.mem_pending  (mem_pending),
		.mem_complete (mem_complete),
		.rq_val       (m_val),
		.rq_type      (m_type),
		.rq_size      (m_size),
		.rq_address   (m_address),
		.rq_data      (m_data),
		.req_ack      (m_req_ack)
	);

	port_arbiter u_arb (
		.clk                       (clk),
		.nrst                      (nrst),
		.mem_pending               (mem_pending),
		.mem_complete              (mem_complete),
		.fetch_wait_resp           (fetch_wait_resp),
		.f_val                     (f_val),
		.f_address                 (f_address),
		.f_req_ack                 (f_req_ack),
		.m_val                     (m_val),
		.m_type                    (m_type),
		.m_size                    (m_size),
		.m_address                 (m_address),
		.m_data                    (m_data),
		.m_req_ack                 (m_req_ack),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.f_header_ack              (f_header_ack),
		.f_resp_val                (f_resp_val),
		.m_header_ack              (m_header_ack),
		.m_ack                     (m_ack),
		.m_resp_val                (m_resp_val),
		.resp_data                 (resp_data)
	);

endmodule

//--- test/tb_l15_port_share.sv
`timescale 1ns/1ps
`include "l15_share_config.svh"

module tb_l15_port_share;
	import l15_share_pkg::*;

	logic    clk;
	logic    nrst;
	logic    fetch_req;
	addr_t   fetch_addr;
	logic    fetch_valid;
	word_t   fetch_instr;
	logic    mem_req;
	logic    mem_wr;
	rqsize_t mem_size;
	addr_t   mem_addr;
	word_t   mem_wdata;
	logic    mem_done;
	word_t   mem_rdata;
	rqtype_t transducer_l15_rqtype;
	rqsize_t transducer_l15_size;
	addr_t   transducer_l15_address;
	dword_t  transducer_l15_data;
	logic    transducer_l15_val;
	logic    transducer_l15_req_ack;
	logic    l15_transducer_header_ack;
	logic    l15_transducer_ack;
	logic    l15_transducer_val;
	dword_t  l15_transducer_data_0;

	// Expected fields of the operations in flight
	addr_t   f_addr_exp = '0;
	addr_t   m_addr_exp = '0;
	rqsize_t m_size_exp = '0;
	word_t   m_wdata_exp = '0;
	logic    m_wr_exp = 1'b0;
	rqtype_t m_type_exp;

	int   fetch_issued = 0;
	int   fetch_seen = 0;
	int   mem_issued = 0;
	int   mem_seen = 0;
	logic fetch_open;
	logic mem_open;
	logic resp_d = 1'b0; // L1.5 response one cycle back
	logic ack_d = 1'b0;
	logic fill_open = 1'b0; // Fill granted, response not returned yet
	logic fill_rq;
	logic data_rq;
	int   rst_cycles = 0;
	int   min_resp_delay = 1;
	int   errors = 0;
	int   tests = 0;
	int   passed = 0;

	assign fetch_open = (fetch_issued != fetch_seen);
	assign mem_open   = (mem_issued != mem_seen);
	assign m_type_exp = m_wr_exp ? `L15_RQ_STORE : `L15_RQ_LOAD;
	assign fill_rq    = transducer_l15_val && (transducer_l15_rqtype == `L15_RQ_IMISS);
	assign data_rq    = transducer_l15_val && (transducer_l15_rqtype != `L15_RQ_IMISS);

	l15_port_share u_l15_port_share (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		resp_d <= l15_transducer_val;
		ack_d  <= l15_transducer_ack;
		if (!nrst)
			rst_cycles <= rst_cycles + 1;
		if (fetch_valid)
			fetch_seen <= fetch_seen + 1;
		if (mem_done)
			mem_seen <= mem_seen + 1;
	end

	// Word at A is A aligned down to 4, xor a fixed tag
	function automatic word_t word_at(input addr_t a);
		return {a[`L15_ADDR_W-1:2], 2'b00} ^ 32'hC0DE_0000;
	endfunction

	function automatic dword_t beat_at(input addr_t a);
		return {word_at({a[`L15_ADDR_W-1:3], 3'b100}),
			word_at({a[`L15_ADDR_W-1:3], 3'b000})};
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		errors++;
		$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
	endtask

	task automatic report_problem(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic abort_run(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	reset_chk: assert property (@(posedge clk) (!nrst && rst_cycles != 0) |->
		!transducer_l15_val && !transducer_l15_req_ack && !fetch_valid && !mem_done)
		else report_problem("outputs not all low during reset");
	fill_owner_chk: assert property (@(posedge clk) disable iff (!nrst) fill_rq |-> fetch_open)
		else report_problem("fill request on the port with no fetch outstanding");
	fill_size_chk: assert property (@(posedge clk) disable iff (!nrst)
		fill_rq |-> transducer_l15_size == `L15_SIZE_WORD)
		else report_mismatch("transducer_l15_size", $sampled(transducer_l15_size), `L15_SIZE_WORD);
	fill_addr_chk: assert property (@(posedge clk) disable iff (!nrst)
		fill_rq |-> transducer_l15_address == f_addr_exp)
		else report_mismatch("transducer_l15_address", $sampled(transducer_l15_address),
			$sampled(f_addr_exp));
	data_owner_chk: assert property (@(posedge clk) disable iff (!nrst) data_rq |-> mem_open)
		else report_problem("load or store request with no data operation outstanding");
	// No data request may overtake a granted fill
	data_block_chk: assert property (@(posedge clk) disable iff (!nrst) data_rq |-> !fill_open)
		else report_problem("load or store on the port while a fill is outstanding");
	data_type_chk: assert property (@(posedge clk) disable iff (!nrst)
		data_rq |-> transducer_l15_rqtype == m_type_exp)
		else report_mismatch("transducer_l15_rqtype", $sampled(transducer_l15_rqtype),
			$sampled(m_type_exp));
	data_size_chk: assert property (@(posedge clk) disable iff (!nrst)
		data_rq |-> transducer_l15_size == m_size_exp)
		else report_mismatch("transducer_l15_size", $sampled(transducer_l15_size),
			$sampled(m_size_exp));
	data_addr_chk: assert property (@(posedge clk) disable iff (!nrst)
		data_rq |-> transducer_l15_address == m_addr_exp)
		else report_mismatch("transducer_l15_address", $sampled(transducer_l15_address),
			$sampled(m_addr_exp));
	store_data_chk: assert property (@(posedge clk) disable iff (!nrst)
		(data_rq && m_wr_exp) |-> transducer_l15_data == {m_wdata_exp, m_wdata_exp})
		else report_mismatch("transducer_l15_data", $sampled(transducer_l15_data),
			{$sampled(m_wdata_exp), $sampled(m_wdata_exp)});
	// Response ack only in the response cycle
	req_ack_chk: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_req_ack == l15_transducer_val)
		else report_mismatch("transducer_l15_req_ack", $sampled(transducer_l15_req_ack),
			$sampled(l15_transducer_val));
	fetch_valid_chk: assert property (@(posedge clk) disable iff (!nrst)
		fetch_valid |-> fetch_open && resp_d)
		else report_problem("fetch_valid without an outstanding fetch and its response");
	instr_chk: assert property (@(posedge clk) disable iff (!nrst)
		fetch_valid |-> fetch_instr == word_at(f_addr_exp))
		else report_mismatch("fetch_instr", $sampled(fetch_instr), word_at($sampled(f_addr_exp)));
	mem_done_chk: assert property (@(posedge clk) disable iff (!nrst)
		mem_done |-> mem_open && (m_wr_exp ? ack_d : resp_d))
		else report_problem("mem_done without an outstanding operation and its completion");
	rdata_chk: assert property (@(posedge clk) disable iff (!nrst)
		(mem_done && !m_wr_exp) |-> mem_rdata == word_at(m_addr_exp))
		else report_mismatch("mem_rdata", $sampled(mem_rdata), word_at($sampled(m_addr_exp)));

	// L1.5 responder, one transaction at a time
	task automatic serve_request;
		int      n;
		rqtype_t typ;
		addr_t   a;
		repeat ($urandom_range(3, 0)) @(posedge clk);
		l15_transducer_header_ack <= 1'b1;
		@(posedge clk);
		n = 1;
		while (!transducer_l15_val && n < 50)
		begin
			@(posedge clk);
			n++;
		end
		if (!transducer_l15_val)
			abort_run("request on the L1.5 port never granted");
		typ = transducer_l15_rqtype; // Fields at the grant edge
		a   = transducer_l15_address;
		l15_transducer_header_ack <= 1'b0;
		if (typ == `L15_RQ_IMISS)
			fill_open <= 1'b1;
		repeat ($urandom_range(5, min_resp_delay)) @(posedge clk);
		if (typ == `L15_RQ_STORE)
			l15_transducer_ack <= 1'b1;
		else
		begin
			l15_transducer_val    <= 1'b1;
			l15_transducer_data_0 <= beat_at(a);
		end
		@(posedge clk);
		l15_transducer_ack <= 1'b0;
		l15_transducer_val <= 1'b0;
		fill_open          <= 1'b0;
	endtask

	initial
	begin
		l15_transducer_header_ack = 1'b0;
		l15_transducer_ack        = 1'b0;
		l15_transducer_val        = 1'b0;
		l15_transducer_data_0     = '0;
		forever
		begin
			@(posedge clk);
			if (nrst && transducer_l15_val)
				serve_request();
		end
	end

	task automatic start_fetch(input addr_t a, input logic counted);
		fetch_req  <= 1'b1;
		fetch_addr <= a;
		if (counted)
		begin
			f_addr_exp   <= a;
			fetch_issued <= fetch_issued + 1;
		end
		@(posedge clk);
		fetch_req <= 1'b0;
	endtask

	task automatic start_mem(input logic wr, input rqsize_t size, input addr_t a,
		input word_t wd);
		mem_req     <= 1'b1;
		mem_wr      <= wr;
		mem_size    <= size;
		mem_addr    <= a;
		mem_wdata   <= wd;
		m_wr_exp    <= wr;
		m_size_exp  <= size;
		m_addr_exp  <= a;
		m_wdata_exp <= wd;
		mem_issued  <= mem_issued + 1;
		@(posedge clk);
		mem_req <= 1'b0;
	endtask

	task automatic wait_all_done;
		int n;
		n = 0;
		while ((fetch_open || mem_open) && n < 200)
		begin
			@(posedge clk);
			n++;
		end
		if (fetch_open || mem_open)
			abort_run("fetch_valid or mem_done never arrived");
	endtask

	task automatic wait_grant;
		int n;
		n = 0;
		while (!(transducer_l15_val && l15_transducer_header_ack) && n < 50)
		begin
			@(posedge clk);
			n++;
		end
		if (!(transducer_l15_val && l15_transducer_header_ack))
			abort_run("fill request never granted");
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before)
		begin
			passed++;
			$display("test %0d %s: ok", tests, name);
		end
		else
			$display("test %0d %s: %0d error(s)", tests, name, errors - errs_before);
	endtask

	initial
	begin
		int errs;
		void'($urandom(38295));
		nrst       = 1'b0;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		mem_req    = 1'b0;
		mem_wr     = 1'b0;
		mem_size   = '0;
		mem_addr   = '0;
		mem_wdata  = '0;
		repeat (4) @(posedge clk);
		nrst <= 1'b1;
		@(posedge clk);
		report_test("reset values", 0);

		errs = errors;
		start_fetch(32'h0000_1000, 1'b1);
		wait_all_done();
		report_test("fetch low word", errs);

		errs = errors;
		start_fetch(32'h0000_2344, 1'b1);
		wait_all_done();
		report_test("fetch high word", errs);

		errs = errors;
		start_mem(1'b0, 3'b001, 32'h0000_3a0c, '0); // Odd size code to see it pass through
		wait_all_done();
		report_test("load", errs);

		errs = errors;
		start_mem(1'b1, `L15_SIZE_WORD, 32'h0000_4418, $urandom());
		wait_all_done();
		report_test("store", errs);

		// Slow fill so the data request has to wait behind it
		errs = errors;
		min_resp_delay = 3;
		start_fetch(32'h0000_5004, 1'b1);
		wait_grant();
		start_mem(1'b0, `L15_SIZE_WORD, 32'h0000_6010, '0);
		wait_all_done();
		min_resp_delay = 1;
		report_test("data request behind fill", errs);

		errs = errors;
		start_fetch(32'h0000_7008, 1'b1);
		start_fetch(32'h0000_9990, 1'b0); // Client busy
		wait_all_done();
		repeat (10) @(posedge clk); // Room for a stray request or pulse
		report_test("strobe while busy", errs);

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests, passed, tests - passed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- l15_port_share.f
+incdir+src
src/l15_share_pkg.sv
src/fetch_client.sv
src/mem_client.sv
src/port_arbiter.sv
src/l15_port_share.sv
test/tb_l15_port_share.sv
